//--- Makefile
# Verilator build for the memory bank testbench.
# The run target fails when the simulation exits with a failing status.

VERILATOR ?= verilator
TOP       ?= tb_mem_bank
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- apb_config_port.sv
`timescale 1ns/1ps
`default_nettype none

// APB completer for the configuration side of the bank.
// Writes finish in their first access cycle. Reads take two, since the SRAM
// needs a cycle to return data. The first cycle issues the read and the
// second presents it with pready.
module apb_config_port (
    input  wire                                         clk,
    input  wire                                         reset,

    // APB completer signals.
    input  wire                                         psel,
    input  wire                                         penable,
    input  wire                                         pwrite,
    input  wire [bank_geom_pkg::bank_addr_width-1:0]    paddr,
    input  wire [bank_geom_pkg::config_data_width-1:0]  pwdata,
    output logic [bank_geom_pkg::config_data_width-1:0] prdata,
    output logic                                        pready,
    output logic                                        pslverr,

    // Configuration strobes to the controller.
    output logic                                        config_en,
    output logic                                        config_wr,
    output logic                                        config_rd,
    output logic [bank_geom_pkg::bank_addr_width-1:0]   config_addr,
    output logic [bank_geom_pkg::config_data_width-1:0] config_wr_data,
    input  wire [bank_geom_pkg::config_data_width-1:0]  config_rd_data
);

    import bank_geom_pkg::*;

    logic                           access;     // APB access phase.
    logic                           read_phase; // Second access cycle of a read.
    logic [config_data_width-1:0]   prdata_reg; // Last read result.

    assign access = psel && penable;

    // The controller owns the SRAM for every access cycle.
    assign config_en      = access;
    assign config_wr      = access && pwrite;
    assign config_rd      = access && !pwrite && !read_phase;  // Read issue cycle only.
    assign config_addr    = paddr;
    assign config_wr_data = pwdata;

    // Set after the read is issued, then clears once the data has gone out.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_phase <= 1'b0;
        end else begin
            read_phase <= access && !pwrite && !read_phase;
        end
    end

    // Writes complete at once, reads one cycle later.
    assign pready  = access && (pwrite || read_phase);
    assign pslverr = 1'b0;  // Every address in the bank is valid.

    // The read result is kept so prdata stays put after the transfer.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prdata_reg <= '0;
        end else if (access && read_phase) begin
            prdata_reg <= config_rd_data;
        end
    end

    // In the completing cycle the fresh half goes straight out.
    assign prdata = read_phase ? config_rd_data : prdata_reg;

    // The requester has to open a transfer with a setup phase.
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) $rose(penable) |-> psel
    ) else $error("apb_config_port: penable rose without psel");

endmodule

`default_nettype wire

//--- bank_geom_pkg.sv
`default_nettype none

// Geometry of one accelerator memory bank.
// Both the data port and the configuration port address the bank in bytes,
// and the SRAM itself is indexed by 64-bit word.
package bank_geom_pkg;

    localparam int bank_data_width = 64;    // One SRAM word in bits.
    localparam int bank_addr_width = 12;    // Byte address width on both ports.
    localparam int config_data_width = 32;  // APB data bus width.

    // Byte-select bits that sit below the word index.
    localparam int addr_offset = $clog2(bank_data_width / 8);

    // Width of the SRAM word address after the byte select is dropped.
    localparam int word_index_width = bank_addr_width - addr_offset;

    // The top byte-select bit picks the low or the high 32-bit half.
    localparam int half_select_bit = addr_offset - 1;

endpackage

`default_nettype wire

//--- bank_word_pkg.sv
`default_nettype none

// One bank word seen two ways.
// The data port moves it as a single 64-bit vector, while the
// configuration side assembles and reads it back in 32-bit halves.
package bank_word_pkg;

    typedef union packed {
        // Full word as stored in the SRAM.
        logic [bank_geom_pkg::bank_data_width-1:0] whole;
        // Same bits split for the 32-bit configuration bus.
        struct packed {
            logic [bank_geom_pkg::config_data_width-1:0] high;  // Bits 63 to 32.
            logic [bank_geom_pkg::config_data_width-1:0] low;   // Bits 31 to 0.
        } halves;
    } bank_word_t;

endpackage

`default_nettype wire

//--- list.f
bank_geom_pkg.sv
bank_word_pkg.sv
sram_macro.sv
sram_controller.sv
apb_config_port.sv
mem_bank_top.sv
tb_mem_bank.sv

//--- mem_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

// One memory bank of the tile. The APB configuration port and the data
// port share a single SRAM through the controller.
module mem_bank_top (
    input  wire                                         clk,
    input  wire                                         reset,

    // Data port.
    input  wire                                         ren,
    input  wire                                         wen,
    input  wire [bank_geom_pkg::bank_addr_width-1:0]    addr,
    input  wire [bank_geom_pkg::bank_data_width-1:0]    data_in,
    output wire [bank_geom_pkg::bank_data_width-1:0]    data_out,
    output wire                                         data_stall,

    // APB configuration port.
    input  wire                                         psel,
    input  wire                                         penable,
    input  wire                                         pwrite,
    input  wire [bank_geom_pkg::bank_addr_width-1:0]    paddr,
    input  wire [bank_geom_pkg::config_data_width-1:0]  pwdata,
    output wire [bank_geom_pkg::config_data_width-1:0]  prdata,
    output wire                                         pready,
    output wire                                         pslverr
);

    import bank_geom_pkg::*;

    wire                            config_en;
    wire                            config_wr;
    wire                            config_rd;
    wire [bank_addr_width-1:0]      config_addr;
    wire [config_data_width-1:0]    config_wr_data;
    wire [config_data_width-1:0]    config_rd_data;
    wire                            cen;
    wire                            mem_wen;
    wire [word_index_width-1:0]     mem_addr;
    wire [bank_data_width-1:0]      mem_wdata;
    wire [bank_data_width-1:0]      mem_rdata;

    apb_config_port u_apb_config_port (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .config_en(config_en), .config_wr(config_wr), .config_rd(config_rd),
        .config_addr(config_addr), .config_wr_data(config_wr_data),
        .config_rd_data(config_rd_data)
    );

    sram_controller u_sram_controller (
        .clk(clk), .reset(reset),
        .ren(ren), .wen(wen), .addr(addr), .data_in(data_in),
        .data_out(data_out), .data_stall(data_stall),
        .config_en(config_en), .config_wr(config_wr), .config_rd(config_rd),
        .config_addr(config_addr), .config_wr_data(config_wr_data),
        .config_rd_data(config_rd_data),
        .cen(cen), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    // Single-port SRAM behind the controller.
    sram_macro u_sram_macro (
        .clk(clk),
        .cen(cen), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- sram_controller.sv
`timescale 1ns/1ps
`default_nettype none

// Shared-memory arbiter for one bank.
// Configuration accesses take the SRAM ahead of the data port, and the data
// port is told so through data_stall. Configuration writes come in halves.
// The low half waits in a buffer and the high half commits the whole word.
module sram_controller (
    input  wire                                         clk,
    input  wire                                         reset,

    // Data port.
    input  wire                                         ren,
    input  wire                                         wen,
    input  wire [bank_geom_pkg::bank_addr_width-1:0]    addr,
    input  wire [bank_geom_pkg::bank_data_width-1:0]    data_in,
    output logic [bank_geom_pkg::bank_data_width-1:0]   data_out,
    output logic                                        data_stall,

    // Configuration strobes from the APB port.
    input  wire                                         config_en,
    input  wire                                         config_wr,
    input  wire                                         config_rd,
    input  wire [bank_geom_pkg::bank_addr_width-1:0]    config_addr,
    input  wire [bank_geom_pkg::config_data_width-1:0]  config_wr_data,
    output logic [bank_geom_pkg::config_data_width-1:0] config_rd_data,

    // SRAM macro side.
    output logic                                        cen,
    output logic                                        mem_wen,
    output logic [bank_geom_pkg::word_index_width-1:0]  mem_addr,
    output logic [bank_geom_pkg::bank_data_width-1:0]   mem_wdata,
    input  wire [bank_geom_pkg::bank_data_width-1:0]    mem_rdata
);

    import bank_geom_pkg::*;
    import bank_word_pkg::*;

    logic                           config_wr_buffed;   // Low half is waiting.
    logic [config_data_width-1:0]   config_wr_buffer;   // The waiting low half.
    logic                           mem_ren;            // SRAM read issued this cycle.
    logic                           mem_ren_delay;      // Read data is on mem_rdata.
    logic [bank_data_width-1:0]     data_out_reg;       // Last word read.
    logic                           config_hi_half;     // Config address hits the high half.
    bank_word_t                     commit_word;        // Word built from two halves.
    bank_word_t                     read_word;          // Read-back word split in halves.

    assign config_hi_half = config_addr[half_select_bit];

    // The data port waits whenever the configuration side owns the SRAM,
    // including the second cycle of a configuration read.
    assign data_stall = config_en;

    // Low-half configuration writes are parked here. Any high-half write
    // empties the buffer again, whether or not it commits.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            config_wr_buffed <= 1'b0;
        end else if (config_en && config_wr) begin
            config_wr_buffed <= !config_hi_half;
        end
    end

    always_ff @(posedge clk) begin
        if (config_en && config_wr && !config_hi_half) begin
            config_wr_buffer <= config_wr_data;
        end
    end

    // New high half on top, buffered low half below.
    always_comb begin
        commit_word.halves.high = config_wr_data;
        commit_word.halves.low  = config_wr_buffer;
    end

    // SRAM request mux. Configuration wins, the data port gets the rest.
    always_comb begin
        cen       = 1'b0;
        mem_wen   = 1'b0;
        mem_ren   = 1'b0;
        mem_addr  = addr[addr_offset +: word_index_width];
        mem_wdata = data_in;
        if (config_en) begin
            mem_addr = config_addr[addr_offset +: word_index_width];
            if (config_wr && config_hi_half && config_wr_buffed) begin
                cen       = 1'b1;   // Full word is ready, so commit it.
                mem_wen   = 1'b1;
                mem_wdata = commit_word.whole;
            end else if (config_rd) begin
                cen     = 1'b1;     // First access cycle of a config read.
                mem_ren = 1'b1;
            end
            // Anything else is a buffer load or the second read cycle.
        end else begin
            cen     = ren | wen;
            mem_wen = wen;
            mem_ren = ren & ~wen;   // A write takes the cycle if both are up.
        end
    end

    // Remember that a read went out so its data is picked up next cycle.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ren_delay <= 1'b0;
            data_out_reg  <= '0;
        end else begin
            mem_ren_delay <= mem_ren;
            data_out_reg  <= data_out;  // Holds the word until the next read.
        end
    end

    assign data_out = mem_ren_delay ? mem_rdata : data_out_reg;

    // Config read-back takes one half of the word just read.
    assign read_word.whole = data_out;
    assign config_rd_data  = config_hi_half ? read_word.halves.high : read_word.halves.low;

    // The APB port decodes a single transfer direction, so both strobes
    // together would mean the two blocks disagree on the phase.
    a_cfg_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(config_wr && config_rd)
    ) else $error("sram_controller: config_wr and config_rd both high");

    // Read-back data only appears in the cycle after the issue, so the
    // configuration side must still own the SRAM then without a new issue.
    a_cfg_read_data_cycle: assert property (
        @(posedge clk) disable iff (reset) config_rd |=> config_en && !config_rd
    ) else $error("sram_controller: config read not followed by its data cycle");

endmodule

`default_nettype wire

//--- sram_macro.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral model of a single-port SRAM macro.
// One access per cycle. Writes land on the clock edge, and read data comes
// out of a register one cycle after the request is sampled.
module sram_macro (
    input  wire                                         clk,
    input  wire                                         cen,        // Chip enable.
    input  wire                                         mem_wen,    // High for write.
    input  wire [bank_geom_pkg::word_index_width-1:0]   mem_addr,
    input  wire [bank_geom_pkg::bank_data_width-1:0]    mem_wdata,
    output logic [bank_geom_pkg::bank_data_width-1:0]   mem_rdata
);

    import bank_geom_pkg::*;

    // Storage array, one entry per word index.
    logic [bank_data_width-1:0] mem [0:(1 << word_index_width)-1];

    // One port, so an enabled cycle either writes or reads.
    always_ff @(posedge clk) begin
        if (cen) begin
            if (mem_wen) begin
                mem[mem_addr] <= mem_wdata;     // Write on the enabling edge.
            end else begin
                mem_rdata <= mem[mem_addr];     // Registered read.
            end
        end
    end

    // An enabled access must point at a real entry, or the array silently
    // returns or corrupts garbage.
    a_addr_known: assert property (
        @(posedge clk) cen |-> !$isunknown(mem_addr)
    ) else $error("sram_macro: unknown address with cen high");

endmodule

`default_nettype wire

//--- tb_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for one memory bank. A reference model follows every write
// and predicts the results, and a monitor compares each read at the falling edge.
module tb_mem_bank;

    import bank_geom_pkg::*;

    localparam int clk_period = 10;
    localparam int num_rand_words = 8;      // Words for the data port tests.
    localparam int num_commit_words = 2;    // Words for each half-write test.
    localparam int num_cfg_reads = 4;
    localparam int num_stall_ops = 7;       // Operations in the two stall cases.
    localparam int num_ops = 2 * num_rand_words + 6 * num_commit_words
                             + num_cfg_reads + num_stall_ops;

    logic                           clk;
    logic                           reset;
    logic                           ren;
    logic                           wen;
    logic [bank_addr_width-1:0]     addr;
    logic [bank_data_width-1:0]     data_in;
    logic [bank_data_width-1:0]     data_out;
    logic                           data_stall;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [bank_addr_width-1:0]     paddr;
    logic [config_data_width-1:0]   pwdata;
    logic [config_data_width-1:0]   prdata;
    logic                           pready;
    logic                           pslverr;

    // Reference model of the SRAM and of the low-half buffer.
    logic [bank_data_width-1:0]     ref_mem [1 << word_index_width];
    logic [config_data_width-1:0]   ref_buf;
    logic                           ref_buf_loaded;
    logic [bank_data_width-1:0]     exp_word_q [$];    // One entry per SRAM read.
    logic [config_data_width-1:0]   exp_half_q [$];    // One entry per APB read.
    logic [bank_data_width-1:0]     held_word = '0;    // What data_out must hold.
    logic                           data_read_done;    // Data read taken at last edge.
    logic                           cfg_read_done;     // APB read completes this cycle.
    logic [bank_addr_width-1:0]     word_addr [num_rand_words];

    mem_bank_top UUT (
        .clk(clk), .reset(reset),
        .ren(ren), .wen(wen), .addr(addr), .data_in(data_in),
        .data_out(data_out), .data_stall(data_stall),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Every operation gets 20 cycles, which is far above its real length.
    initial begin
        #(num_ops * 20 * clk_period);
        stop_with_failure("Timeout: the test schedule did not finish in time.");
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %0t ns: %s: got %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    // Expected whole word at a byte address.
    function automatic logic [63:0] expected_word(input logic [bank_addr_width-1:0] a);
        return ref_mem[a[bank_addr_width-1:addr_offset]];
    endfunction

    // Expected 32-bit half, picked the way the APB port addresses it.
    function automatic logic [31:0] expected_half(input logic [bank_addr_width-1:0] a);
        logic [63:0] w;
        w = expected_word(a);
        return a[half_select_bit] ? w[63:32] : w[31:0];
    endfunction

    // A low half waits in the buffer. A high half commits only over a loaded buffer.
    task automatic model_config_write(input logic [bank_addr_width-1:0] a,
                                      input logic [31:0] d);
        if (!a[half_select_bit]) begin
            ref_buf = d;
            ref_buf_loaded = 1'b1;
        end else begin
            if (ref_buf_loaded) ref_mem[a[bank_addr_width-1:addr_offset]] = {d, ref_buf};
            ref_buf_loaded = 1'b0;              // Emptied by any high-half write.
        end
    endtask

    // Called 1 ns after an edge. The request stays up while data_stall is high.
    task automatic data_access(input logic is_write, input logic [bank_addr_width-1:0] a,
                               input logic [63:0] d, input logic expect_stall);
        logic stalled;
        stalled = 1'b0;
        ren = !is_write;
        wen = is_write;
        addr = a;
        data_in = d;
        @(negedge clk);
        while (data_stall) begin
            stalled = 1'b1;
            @(negedge clk);
        end
        if (!is_write) exp_word_q.push_back(expected_word(a));
        @(posedge clk);                         // The accepting edge.
        #1;
        ren = 1'b0;
        wen = 1'b0;
        if (is_write) ref_mem[a[bank_addr_width-1:addr_offset]] = d;
        check_value(64'(stalled), 64'(expect_stall), "data_stall seen by requester");
    endtask

    // Setup phase, then access cycles until pready.
    task automatic apb_transfer(input logic is_write, input logic [bank_addr_width-1:0] a,
                                input logic [31:0] d);
        int access_cycles;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = is_write;
        paddr = a;
        pwdata = d;
        @(posedge clk);
        #1;
        penable = 1'b1;
        access_cycles = 1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
            access_cycles++;
        end
        check_value(64'(access_cycles), is_write ? 64'd1 : 64'd2, "APB access cycles");
        @(posedge clk);                         // Transfer ends here.
        #1;
        psel = 1'b0;
        penable = 1'b0;
        if (is_write) model_config_write(a, d);
    endtask

    task automatic apb_read(input logic [bank_addr_width-1:0] a);
        exp_word_q.push_back(expected_word(a));
        exp_half_q.push_back(expected_half(a));
        apb_transfer(1'b0, a, '0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Inputs settle 1 ns after the edge, so the edge sees them stable.
    always @(posedge clk) data_read_done <= !reset && ren && !wen && !data_stall;

    assign cfg_read_done = psel && penable && !pwrite && pready;

    // A finished read must show its word, and otherwise data_out holds.
    always @(negedge clk) begin
        if (!reset) begin
            if (data_read_done || cfg_read_done) begin
                if (exp_word_q.size() == 0) begin
                    stop_with_failure("A read completed with no expected word queued.");
                end else begin
                    held_word = exp_word_q.pop_front();
                    check_value(data_out, held_word, "data_out after read");
                end
            end else begin
                check_value(data_out, held_word, "data_out hold");
            end
            if (cfg_read_done) begin
                if (exp_half_q.size() == 0) begin
                    stop_with_failure("An APB read completed with no expected half queued.");
                end else begin
                    check_value(64'(prdata), 64'(exp_half_q.pop_front()), "prdata");
                    check_value(64'(pslverr), 64'd0, "pslverr");
                end
            end
        end
    end

    initial begin
        logic [bank_addr_width-1:0] a;
        void'($urandom(89710));
        reset = 1'b1;
        {ren, wen, psel, penable, pwrite} = '0;
        addr = '0;
        data_in = '0;
        paddr = '0;
        pwdata = '0;
        ref_buf = '0;
        ref_buf_loaded = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Whole words through the data port, then read back with idle gaps.
        for (int i = 0; i < num_rand_words; i++) begin
            word_addr[i] = 12'($urandom());
            data_access(1'b1, word_addr[i], {$urandom(), $urandom()}, 1'b0);
        end
        for (int i = 0; i < num_rand_words; i++) begin
            data_access(1'b0, word_addr[i], '0, 1'b0);
            idle_cycles(2);
        end

        // Low half then high half commits the word.
        for (int i = 0; i < num_commit_words; i++) begin
            a = 12'($urandom());
            a[half_select_bit] = 1'b0;
            apb_transfer(1'b1, a, $urandom());
            a[half_select_bit] = 1'b1;
            apb_transfer(1'b1, a, $urandom());
            data_access(1'b0, a, '0, 1'b0);
        end

        // A high half with an empty buffer must leave the word alone.
        for (int i = 0; i < num_commit_words; i++) begin
            a = 12'($urandom());
            data_access(1'b1, a, {$urandom(), $urandom()}, 1'b0);
            a[half_select_bit] = 1'b1;
            apb_transfer(1'b1, a, $urandom());
            data_access(1'b0, a, '0, 1'b0);
        end

        // Halves of data port words read back over APB, low and high in turn.
        for (int i = 0; i < num_cfg_reads; i++) begin
            a = word_addr[i];
            a[half_select_bit] = i[0];
            apb_read(a);
        end

        // A data read held off by an APB write, then the commit is read back.
        a = word_addr[0];
        a[half_select_bit] = 1'b0;
        fork
            apb_transfer(1'b1, a, $urandom());
            begin
                @(posedge clk);
                #1;
                data_access(1'b0, word_addr[1], '0, 1'b1);
            end
        join
        a[half_select_bit] = 1'b1;
        apb_transfer(1'b1, a, $urandom());
        data_access(1'b0, word_addr[0], '0, 1'b0);

        // A data write held off by an APB read of the same word.
        fork
            apb_read(word_addr[2]);
            begin
                @(posedge clk);
                #1;
                data_access(1'b1, word_addr[2], {$urandom(), $urandom()}, 1'b1);
            end
        join
        data_access(1'b0, word_addr[2], '0, 1'b0);

        idle_cycles(2);
        if (exp_word_q.size() != 0 || exp_half_q.size() != 0) begin
            stop_with_failure("Some expected reads never completed.");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
